//--- common/revive_defines.svh
`ifndef REVIVE_DEFINES_SVH
`define REVIVE_DEFINES_SVH

// Core widths and sizes
`define REVIVE_XLEN          32
`define REVIVE_NREGS         32

// First fetch address after reset
`define REVIVE_RESET_VECTOR  32'h0000_0000

// addi x0, x0, 0
`define REVIVE_NOP           32'h0000_0013

// AHB-lite encodings and tie-offs
`define REVIVE_HSIZE_WORD    3'b010
`define REVIVE_HBURST_SINGLE 3'b000
// Non-cacheable, non-bufferable, privileged data access
`define REVIVE_HPROT_TIE     4'b0011
`define REVIVE_HMASTLOCK_TIE 1'b0

`endif

//--- common/rv_isa_pkg.sv
`include "revive_defines.svh"

package rv_isa_pkg;

	typedef logic [`REVIVE_XLEN-1:0] word_t;
	typedef logic [$clog2(`REVIVE_NREGS)-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_e;

	// Picks bus path in the sequencer and next pc in pc_counter
	typedef enum logic [2:0] {
		IC_ALU, IC_LOAD, IC_STORE, IC_BEQ, IC_BNE, IC_JAL, IC_LUI, IC_NONE
	} instr_class_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_LOAD, WB_LINK
	} wb_src_e;

	typedef struct packed {
		reg_idx_t     rs1;
		reg_idx_t     rs2;
		reg_idx_t     rd;
		word_t        imm;
		alu_op_e      alu_op;
		logic         use_imm;
		instr_class_e iclass;
		wb_src_e      wb_src;
		logic         rd_we;
	} decoded_t;

endpackage

//--- common/ahb_pkg.sv
`include "revive_defines.svh"

package ahb_pkg;

	typedef logic [`REVIVE_XLEN-1:0] bus_word_t;

	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10
	} htrans_e;

	typedef struct packed {
		bus_word_t  haddr;
		logic       hwrite;
		htrans_e    htrans;
		logic [2:0] hsize;
		logic [2:0] hburst;
		logic [3:0] hprot;
		logic       hmastlock;
		bus_word_t  hwdata;
	} ahb_req_t;

	typedef struct packed {
		logic      hready;
		bus_word_t hrdata;
	} ahb_rsp_t;

endpackage

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import rv_isa_pkg::*; (
	input  decoded_t dec_i,
	input  word_t    rs1_i,
	input  word_t    rs2_i,
	output word_t    result_o,
	output logic     zero_o
);

	word_t      op_a;
	word_t      op_b;
	logic [4:0] shamt;

	// LUI is just zero plus the upper immediate
	assign op_a  = (dec_i.iclass == IC_LUI) ? '0 : rs1_i;
	assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec_i.alu_op)
			ALU_SUB:  result_o = op_a - op_b;
			ALU_AND:  result_o = op_a & op_b;
			ALU_OR:   result_o = op_a | op_b;
			ALU_XOR:  result_o = op_a ^ op_b;
			ALU_SLT:  result_o = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: result_o = {31'b0, op_a < op_b};
			ALU_SLL:  result_o = op_a << shamt;
			ALU_SRL:  result_o = op_a >> shamt;
			ALU_SRA:  result_o = word_t'($signed(op_a) >>> shamt);
			default:  result_o = op_a + op_b;
		endcase
	end

	// Branch condition source
	assign zero_o = (result_o == '0);

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

`include "revive_defines.svh"

module regfile import rv_isa_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  decoded_t dec_i,
	input  logic     exec_i,
	input  logic     mem_done_i,
	input  word_t    alu_i,
	input  word_t    load_i,
	input  word_t    link_i,
	output word_t    rs1_data_o,
	output word_t    rs2_data_o
);

	// x0 has no storage
	word_t regs [1:`REVIVE_NREGS-1];
	word_t wdata;
	logic  we;

	// Loads write back only once their data phase completes
	assign we = dec_i.rd_we && (dec_i.rd != '0) &&
		(dec_i.iclass == IC_LOAD ? mem_done_i : exec_i);

	always_comb begin
		case (dec_i.wb_src)
			WB_LOAD: wdata = load_i;
			WB_LINK: wdata = link_i;
			default: wdata = alu_i;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `REVIVE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[dec_i.rd] <= wdata;
		end
	end

	assign rs1_data_o = (dec_i.rs1 == '0) ? '0 : regs[dec_i.rs1];
	assign rs2_data_o = (dec_i.rs2 == '0) ? '0 : regs[dec_i.rs2];

endmodule

//--- rtl/pc_counter.sv
`timescale 1ns/1ps

`include "revive_defines.svh"

module pc_counter import rv_isa_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     exec_i,
	input  decoded_t dec_i,
	input  logic     zero_i,
	output word_t    pc_o,
	output word_t    link_o
);

	word_t pc;
	logic  taken;

	// Branches compare by subtraction in the ALU
	assign taken = (dec_i.iclass == IC_JAL) ||
		(dec_i.iclass == IC_BEQ && zero_i) ||
		(dec_i.iclass == IC_BNE && !zero_i);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `REVIVE_RESET_VECTOR;
		end else if (exec_i) begin
			pc <= taken ? pc + dec_i.imm : pc + 32'd4;
		end
	end

	assign pc_o   = pc;
	assign link_o = pc + 32'd4;

endmodule

//--- rtl/instr_decoder.sv
`timescale 1ns/1ps

`include "revive_defines.svh"

module instr_decoder import rv_isa_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     ir_load_i,
	input  word_t    hrdata_i,
	output decoded_t dec_o
);

	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	word_t      ir;
	logic [2:0] funct3;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

	// Shared by register and immediate forms
	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
			3'b001:  alu_sel = ALU_SLL;
			3'b010:  alu_sel = ALU_SLT;
			3'b011:  alu_sel = ALU_SLTU;
			3'b100:  alu_sel = ALU_XOR;
			3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
			3'b110:  alu_sel = ALU_OR;
			default: alu_sel = ALU_AND;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ir <= `REVIVE_NOP;
		end else if (ir_load_i) begin
			ir <= hrdata_i;
		end
	end

	assign funct3 = ir[14:12];
	assign imm_i  = {{21{ir[31]}}, ir[30:20]};
	assign imm_s  = {{21{ir[31]}}, ir[30:25], ir[11:7]};
	assign imm_b  = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u  = {ir[31:12], 12'h000};
	assign imm_j  = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

	// Anything not listed falls through as a no-op
	always_comb begin
		dec_o.rs1     = ir[19:15];
		dec_o.rs2     = ir[24:20];
		dec_o.rd      = ir[11:7];
		dec_o.imm     = imm_i;
		dec_o.alu_op  = ALU_ADD;
		dec_o.use_imm = 1'b1;
		dec_o.iclass  = IC_NONE;
		dec_o.wb_src  = WB_ALU;
		dec_o.rd_we   = 1'b0;
		case (ir[6:0])
			OP_IMM: begin
				dec_o.iclass = IC_ALU;
				dec_o.rd_we  = 1'b1;
				dec_o.alu_op = alu_sel(funct3, funct3 == 3'b101 && ir[30]);
			end
			OP_REG: begin
				if (ir[31] == 1'b0 && ir[29:25] == 5'b00000) begin
					dec_o.iclass  = IC_ALU;
					dec_o.rd_we   = 1'b1;
					dec_o.use_imm = 1'b0;
					dec_o.alu_op  = alu_sel(funct3, ir[30]);
				end
			end
			OP_LUI: begin
				dec_o.iclass = IC_LUI;
				dec_o.imm    = imm_u;
				dec_o.rd_we  = 1'b1;
			end
			OP_LOAD: begin
				if (funct3 == 3'b010) begin
					dec_o.iclass = IC_LOAD;
					dec_o.wb_src = WB_LOAD;
					dec_o.rd_we  = 1'b1;
				end
			end
			OP_STORE: begin
				if (funct3 == 3'b010) begin
					dec_o.iclass = IC_STORE;
					dec_o.imm    = imm_s;
				end
			end
			OP_BRANCH: begin
				dec_o.imm     = imm_b;
				dec_o.alu_op  = ALU_SUB;
				dec_o.use_imm = 1'b0;
				if (funct3 == 3'b000) begin
					dec_o.iclass = IC_BEQ;
				end else if (funct3 == 3'b001) begin
					dec_o.iclass = IC_BNE;
				end
			end
			OP_JAL: begin
				dec_o.iclass = IC_JAL;
				dec_o.imm    = imm_j;
				dec_o.wb_src = WB_LINK;
				dec_o.rd_we  = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- rtl/bus_master.sv
`timescale 1ns/1ps

`include "revive_defines.svh"

module bus_master import rv_isa_pkg::*; import ahb_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     fetch_addr_i,
	input  logic     mem_addr_i,
	input  decoded_t dec_i,
	input  word_t    pc_i,
	input  word_t    addr_i,
	input  word_t    store_i,
	output ahb_req_t ahb_o
);

	word_t store_q;
	logic  is_store;

	assign is_store = (dec_i.iclass == IC_STORE);

	// Captured every address-phase cycle, so it holds through wait states
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			store_q <= '0;
		end else if (mem_addr_i && is_store) begin
			store_q <= store_i;
		end
	end

	always_comb begin
		ahb_o.htrans = (fetch_addr_i || mem_addr_i) ? HTRANS_NONSEQ : HTRANS_IDLE;
		ahb_o.haddr  = fetch_addr_i ? pc_i : (mem_addr_i ? addr_i : '0);
		ahb_o.hwrite = mem_addr_i && is_store;
		ahb_o.hsize  = `REVIVE_HSIZE_WORD;
		ahb_o.hwdata = store_q;
		// Fixed tie-offs
		ahb_o.hburst    = `REVIVE_HBURST_SINGLE;
		ahb_o.hprot     = `REVIVE_HPROT_TIE;
		ahb_o.hmastlock = `REVIVE_HMASTLOCK_TIE;
	end

endmodule

//--- rtl/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer import rv_isa_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         hready_i,
	input  instr_class_e iclass_i,
	output logic         fetch_addr_o,
	output logic         ir_load_o,
	output logic         exec_o,
	output logic         mem_addr_o,
	output logic         mem_done_o
);

	typedef enum logic [2:0] {
		FETCH_ADDR, FETCH_DATA, EXECUTE, MEM_ADDR, MEM_DATA
	} state_e;

	state_e state;
	state_e state_next;

	// ==============================
	// Next state
	// ==============================

	always_comb begin
		state_next = state;
		case (state)
			FETCH_ADDR: state_next = FETCH_DATA;
			FETCH_DATA: state_next = EXECUTE;
			EXECUTE: begin
				if (iclass_i == IC_LOAD || iclass_i == IC_STORE) begin
					state_next = MEM_ADDR;
				end else begin
					state_next = FETCH_ADDR;
				end
			end
			MEM_ADDR: state_next = MEM_DATA;
			default:  state_next = FETCH_ADDR;
		endcase
	end

	// Reset parks in MEM_DATA, so the bus is idle until the first edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= MEM_DATA;
		end else if (hready_i) begin
			state <= state_next;
		end
	end

	// Address strobes follow the state, completion strobes need hready
	assign fetch_addr_o = (state == FETCH_ADDR);
	assign mem_addr_o   = (state == MEM_ADDR);
	assign ir_load_o    = (state == FETCH_DATA) && hready_i;
	assign exec_o       = (state == EXECUTE) && hready_i;
	assign mem_done_o   = (state == MEM_DATA) && hready_i;

endmodule

//--- rtl/revive_core.sv
`timescale 1ns/1ps

module revive_core import rv_isa_pkg::*; import ahb_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  ahb_rsp_t ahb_i,
	output ahb_req_t ahb_o
);

	logic     fetch_addr;
	logic     ir_load;
	logic     exec;
	logic     mem_addr;
	logic     mem_done;
	decoded_t dec;
	word_t    alu_result;
	logic     alu_zero;
	word_t    rs1_data;
	word_t    rs2_data;
	word_t    pc;
	word_t    link;

	core_sequencer u_seq (
		.clk(clk), .rst_n(rst_n), .hready_i(ahb_i.hready), .iclass_i(dec.iclass),
		.fetch_addr_o(fetch_addr), .ir_load_o(ir_load), .exec_o(exec),
		.mem_addr_o(mem_addr), .mem_done_o(mem_done)
	);

	pc_counter u_pc (
		.clk(clk), .rst_n(rst_n), .exec_i(exec), .dec_i(dec), .zero_i(alu_zero),
		.pc_o(pc), .link_o(link)
	);

	instr_decoder u_dec (
		.clk(clk), .rst_n(rst_n), .ir_load_i(ir_load), .hrdata_i(ahb_i.hrdata),
		.dec_o(dec)
	);

	// Load data goes straight from the bus into the register file
	regfile u_rf (
		.clk(clk), .rst_n(rst_n), .dec_i(dec), .exec_i(exec), .mem_done_i(mem_done),
		.alu_i(alu_result), .load_i(ahb_i.hrdata), .link_i(link),
		.rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
	);

	alu u_alu (
		.dec_i(dec), .rs1_i(rs1_data), .rs2_i(rs2_data),
		.result_o(alu_result), .zero_o(alu_zero)
	);

	bus_master u_bus (
		.clk(clk), .rst_n(rst_n), .fetch_addr_i(fetch_addr), .mem_addr_i(mem_addr),
		.dec_i(dec), .pc_i(pc), .addr_i(alu_result), .store_i(rs2_data), .ahb_o(ahb_o)
	);

endmodule

//--- sim/tb_revive_core.sv
`timescale 1ns/1ps

`include "revive_defines.svh"

module tb_revive_core import rv_isa_pkg::*; import ahb_pkg::*; ();

	localparam int MEM_WORDS     = 256;
	localparam int STORE_TIMEOUT = 5000;
	localparam int DRAIN_CYCLES  = 40;

	typedef logic [8*16-1:0] name_t;

	// One expected store, in program order
	typedef struct packed {
		name_t name;
		word_t addr;
		word_t data;
	} expect_t;

	logic        clk;
	logic        rst_n;
	ahb_rsp_t    rsp;
	ahb_req_t    req;
	word_t       mem [MEM_WORDS];
	expect_t     exp_q [$];
	int          pass_cnt   = 0;
	int          fail_cnt   = 0;
	logic        fetch_seen = 1'b0;
	logic        tie_bad    = 1'b0;
	logic        size_bad   = 1'b0;
	logic [15:0] lfsr       = 16'd39;

	revive_core dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.ahb_i(rsp),
		.ahb_o(req)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Unwritten words get a pattern built from their own address
	task automatic load_memory_image();
		int      fd;
		string   line;
		word_t   addr;
		word_t   data;
		name_t   name;
		expect_t e;
		for (int i = 0; i < MEM_WORDS; i++) begin
			addr   = word_t'(i) << 2;
			mem[i] = {addr[15:0] ^ 16'hA5A5, addr[15:0]};
		end
		fd = $fopen("sim/revive_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file sim/revive_stim.txt");
			fail_cnt++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0) begin
					if ($sscanf(line, "P %h %h", addr, data) == 2) begin
						mem[addr[9:2]] = data;
					end else if ($sscanf(line, "E %s %h %h", name, addr, data) == 3) begin
						e.name = name;
						e.addr = addr;
						e.data = data;
						exp_q.push_back(e);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic compare_store(input word_t addr, input word_t data);
		expect_t e;
		if (exp_q.size() == 0) begin
			$display("Unexpected store of %h to address %h", data, addr);
			fail_cnt++;
		end else begin
			e = exp_q.pop_front();
			if (addr != e.addr) begin
				$display("Fail %0s expected address %h actual address %h", e.name, e.addr, addr);
				fail_cnt++;
			end else if (data != e.data) begin
				$display("Fail %0s expected %h actual %h", e.name, e.data, data);
				fail_cnt++;
			end else begin
				$display("Pass %0s", e.name);
				pass_cnt++;
			end
		end
	endtask

	// Tie-offs hold on every cycle, transfer size on every NONSEQ
	task automatic watch_bus_constants();
		logic [7:0] expected;
		logic [7:0] actual;
		expected = {`REVIVE_HBURST_SINGLE, `REVIVE_HPROT_TIE, `REVIVE_HMASTLOCK_TIE};
		actual   = {req.hburst, req.hprot, req.hmastlock};
		if (actual != expected && !tie_bad) begin
			$display("Fail tieoff expected %b actual %b", expected, actual);
			tie_bad = 1'b1;
			fail_cnt++;
		end
		if (req.htrans == HTRANS_NONSEQ && req.hsize != `REVIVE_HSIZE_WORD &&
			!size_bad) begin
			$display("Fail hsize expected %b actual %b", `REVIVE_HSIZE_WORD, req.hsize);
			size_bad = 1'b1;
			fail_cnt++;
		end
	endtask

	task automatic first_fetch_check();
		if (req.haddr != `REVIVE_RESET_VECTOR) begin
			$display("Fail reset_fetch expected %h actual %h", `REVIVE_RESET_VECTOR, req.haddr);
			fail_cnt++;
		end else if (req.hwrite) begin
			$display("Fail reset_fetch expected hwrite 0 actual 1");
			fail_cnt++;
		end else begin
			$display("Pass reset_fetch");
			pass_cnt++;
		end
	endtask

	// ==============================
	// AHB-lite slave memory
	// ==============================

	initial begin : ahb_slave
		logic  dp_valid;
		logic  dp_write;
		word_t dp_addr;
		dp_valid   = 1'b0;
		dp_write   = 1'b0;
		dp_addr    = '0;
		rsp.hready = 1'b1;
		rsp.hrdata = '0;
		forever begin
			@(posedge clk);
			if (rst_n) begin
				watch_bus_constants();
				if (req.htrans == HTRANS_NONSEQ && !fetch_seen) begin
					first_fetch_check();
					fetch_seen = 1'b1;
				end
				if (rsp.hready) begin
					// Data phase completes, then the next address phase is taken
					if (dp_valid && dp_write) begin
						mem[dp_addr[9:2]] = req.hwdata;
						compare_store(dp_addr, req.hwdata);
					end
					dp_valid = (req.htrans == HTRANS_NONSEQ);
					dp_write = req.hwrite;
					dp_addr  = req.haddr;
				end
				// Wait states only while a data phase is pending
				if (dp_valid) begin
					lfsr = lfsr_next(lfsr);
					rsp.hready <= lfsr[0];
				end else begin
					rsp.hready <= 1'b1;
				end
				rsp.hrdata <= mem[dp_addr[9:2]];
			end
		end
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin : run
		int   cycles;
		logic idle_bad;
		cycles   = 0;
		idle_bad = 1'b0;
		rst_n    = 1'b0;
		load_memory_image();
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			if (req.htrans != HTRANS_IDLE && !idle_bad) begin
				$display("Fail reset_idle expected %b actual %b", HTRANS_IDLE, req.htrans);
				idle_bad = 1'b1;
				fail_cnt++;
			end
		end
		if (!idle_bad) begin
			$display("Pass reset_idle");
			pass_cnt++;
		end
		@(posedge clk);
		rst_n <= 1'b1;

		while (exp_q.size() != 0 && cycles < STORE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("Timed out after %0d cycles with %0d expected stores not seen",
				cycles, exp_q.size());
			fail_cnt++;
		end

		// Any store after the last expected one is flagged here
		repeat (DRAIN_CYCLES) @(posedge clk);
		@(negedge clk);
		if (!fetch_seen) begin
			$display("No instruction fetch was seen after reset");
			fail_cnt++;
		end
		if (!tie_bad) begin
			$display("Pass tieoff");
			pass_cnt++;
		end
		if (!size_bad) begin
			$display("Pass hsize");
			pass_cnt++;
		end
		$display("Tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
			fail_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- revive_core.f
+incdir+common
common/rv_isa_pkg.sv
common/ahb_pkg.sv
rtl/alu.sv
rtl/regfile.sv
rtl/pc_counter.sv
rtl/instr_decoder.sv
rtl/bus_master.sv
rtl/core_sequencer.sv
rtl/revive_core.sv
sim/tb_revive_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_revive_core
FILELIST  ?= revive_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^All tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/revive_stim.txt
# P <byte address> <instruction word>
# E <test name> <store address> <store data>, in program order
P 00000000 20000093
P 00000004 06400113
P 00000008 FF900193
P 0000000C 00310233
P 00000010 0040A023
P 00000014 40218233
P 00000018 0040A223
P 0000001C 00314233
P 00000020 0040A423
P 00000024 0F01F213
P 00000028 0040A623
P 0000002C F0016213
P 00000030 0040A823
P 00000034 0021A233
P 00000038 0040AA23
P 0000003C 0641B213
P 00000040 0040AC23
P 00000044 00211233
P 00000048 0040AE23
P 0000004C 4011D213
P 00000050 0240A023
P 00000054 01C1D213
P 00000058 0240A223
P 0000005C ABCDE2B7
P 00000060 0250A423
P 00000064 0280A303
P 00000068 0260A623
P 0000006C 00210463
P 00000070 0220A823
P 00000074 0230AA23
P 00000078 00310463
P 0000007C 0220AC23
P 00000080 00311463
P 00000084 0220AE23
P 00000088 0430A023
P 0000008C 00211463
P 00000090 0420A223
P 00000094 008003EF
P 00000098 0420A423
P 0000009C 0470A623
P 000000A0 0000006F
E add 00000200 0000005D
E sub 00000204 FFFFFF95
E xor 00000208 FFFFFF9D
E andi 0000020C 000000F0
E ori 00000210 FFFFFF64
E slt 00000214 00000001
E sltiu 00000218 00000000
E sll 0000021C 00000640
E srai 00000220 FFFFFFFC
E srli 00000224 0000000F
E lui_store 00000228 ABCDE000
E lw_store 0000022C ABCDE000
E beq_taken 00000234 FFFFFFF9
E beq_not_taken 00000238 00000064
E bne_taken 00000240 FFFFFFF9
E bne_not_taken 00000244 00000064
E jal_link 0000024C 00000098
